//--- all.f
+incdir+hdl
hdl/cnn_data_pkg.sv
hdl/cnn_stream_pkg.sv
hdl/coeff_loader.sv
hdl/window_gen.sv
hdl/conv_mac.sv
hdl/adder_tree.sv
hdl/conv3x3_layer.sv
test/tb_clock.sv
test/tb_conv3x3_layer.sv

//--- hdl/adder_tree.sv
`timescale 1ns/10ps
`include "cnn_cfg.svh"

module adder_tree (
	input  logic                      clk,
	input  logic                      rst,
	input  cnn_stream_pkg::tap_beat_t taps,
	input  cnn_data_pkg::bias_t       biases [`CNN_OUT_CH],
	output cnn_stream_pkg::result_t   res
);

	import cnn_data_pkg::*;
	import cnn_stream_pkg::*;

	logic     res_valid;
	pos_t     res_pos;
	acc_vec_t data_d;
	acc_vec_t data_q;

	// nine taps plus bias, four adder levels
	function automatic acc_t tree_sum(input acc_t [`CNN_TAPS-1:0] t, input bias_t b);
		acc_t s01, s23, s45, s67, s8b;
		acc_t s03, s47;
		s01 = t[0] + t[1];
		s23 = t[2] + t[3];
		s45 = t[4] + t[5];
		s67 = t[6] + t[7];
		s8b = t[8] + acc_t'(b);
		s03 = s01 + s23;
		s47 = s45 + s67;
		return (s03 + s47) + s8b;
	endfunction

	always_comb
	begin
		for (int oc = 0; oc < `CNN_OUT_CH; oc++)
			data_d[oc] = tree_sum(taps.sums[oc], biases[oc]);
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			res_valid <= 1'b0;
		else
			res_valid <= taps.valid;
	end

	always_ff @(posedge clk)
	begin
		res_pos <= taps.pos;
		data_q  <= data_d;
	end

	assign res = '{valid: res_valid, pos: res_pos, data: data_q};

	a_last_pos: assert property (@(posedge clk) disable iff (rst)
		(res.valid && res.pos.last) |->
		(res.pos.row == `CNN_HEIGHT - 3) && (res.pos.col == `CNN_WIDTH - 3))
		else $error("last flag on a non-final position");

endmodule

//--- hdl/cnn_cfg.svh
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// channel counts
`define CNN_IN_CH    4
`define CNN_OUT_CH   4

// input frame size in pixels
`define CNN_WIDTH    6
`define CNN_HEIGHT   5

// kernel geometry
`define CNN_KSIZE    3
`define CNN_TAPS     9

// operand and result widths
`define CNN_DATA_W   8
`define CNN_BIAS_W   16
`define CNN_ACC_W    24
`define CNN_COORD_W  4

`endif

//--- hdl/cnn_data_pkg.sv
`include "cnn_cfg.svh"

package cnn_data_pkg;

	// one signed channel value of a pixel or a weight
	typedef logic signed [`CNN_DATA_W-1:0] pix_t;

	// all input channels of one pixel, also one weight word
	typedef pix_t [`CNN_IN_CH-1:0] pix_vec_t;

	// tap index is row * 3 + col, row 0 oldest
	typedef pix_vec_t [`CNN_TAPS-1:0] window_t;

	// the nine weight words of one output channel
	typedef pix_vec_t [`CNN_TAPS-1:0] kernel_t;

	typedef logic signed [`CNN_BIAS_W-1:0] bias_t;

	// full width sum, no truncation anywhere
	typedef logic signed [`CNN_ACC_W-1:0] acc_t;

	// one result per output channel
	typedef acc_t [`CNN_OUT_CH-1:0] acc_vec_t;

endpackage

//--- hdl/cnn_stream_pkg.sv
`include "cnn_cfg.svh"

package cnn_stream_pkg;

	import cnn_data_pkg::*;

	typedef logic [`CNN_COORD_W-1:0] coord_t;

	// top-left output position of a window
	typedef struct packed {
		coord_t row;
		coord_t col;
		logic   last;
	} pos_t;

	// window_gen to conv_mac
	typedef struct packed {
		logic    valid;
		pos_t    pos;
		window_t window;
	} win_beat_t;

	// per output channel, per tap dot product
	typedef acc_t [`CNN_OUT_CH-1:0][`CNN_TAPS-1:0] tap_sums_t;

	// conv_mac to adder_tree
	typedef struct packed {
		logic      valid;
		pos_t      pos;
		tap_sums_t sums;
	} tap_beat_t;

	// adder_tree to the layer output
	typedef struct packed {
		logic     valid;
		pos_t     pos;
		acc_vec_t data;
	} result_t;

endpackage

//--- hdl/coeff_loader.sv
`timescale 1ns/10ps
`include "cnn_cfg.svh"

module coeff_loader (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  w_valid,
	input  cnn_data_pkg::pix_vec_t w_data,
	input  logic                  b_valid,
	input  cnn_data_pkg::bias_t   b_data,
	output cnn_data_pkg::kernel_t kernels [`CNN_OUT_CH],
	output cnn_data_pkg::bias_t   biases [`CNN_OUT_CH],
	output logic                  coeff_ready
);

	import cnn_data_pkg::*;

	localparam int W_WORDS = `CNN_OUT_CH * `CNN_TAPS;
	localparam int B_WORDS = `CNN_OUT_CH;

	logic [$clog2(W_WORDS+1)-1:0] w_cnt;
	logic [$clog2(B_WORDS+1)-1:0] b_cnt;
	logic                         w_full;
	logic                         b_full;

	// flat weight chain with word k at index k
	pix_vec_t w_chain [W_WORDS];

	assign w_full = (w_cnt == W_WORDS);
	assign b_full = (b_cnt == B_WORDS);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			w_cnt       <= '0;
			b_cnt       <= '0;
			coeff_ready <= 1'b0;
		end
		else
		begin
			if (w_valid && !w_full)
				w_cnt <= w_cnt + 1'b1;
			if (b_valid && !b_full)
				b_cnt <= b_cnt + 1'b1;
			// sticky once both banks are full
			coeff_ready <= coeff_ready | (w_full & b_full);
		end
	end

	// shift in at the top until the bank is full
	always_ff @(posedge clk)
	begin
		if (w_valid && !w_full)
		begin
			w_chain[W_WORDS-1] <= w_data;
			for (int i = 0; i < W_WORDS - 1; i++)
				w_chain[i] <= w_chain[i+1];
		end
		if (b_valid && !b_full)
		begin
			biases[B_WORDS-1] <= b_data;
			for (int i = 0; i < B_WORDS - 1; i++)
				biases[i] <= biases[i+1];
		end
	end

	// word k goes to channel k / 9 and tap k mod 9
	always_comb
	begin
		for (int f = 0; f < W_WORDS; f++)
			kernels[f / `CNN_TAPS][f % `CNN_TAPS] = w_chain[f];
	end

	a_ready_full: assert property (@(posedge clk) disable iff (rst)
		coeff_ready |-> (w_full && b_full))
		else $error("coeff_ready high before both banks are full");

endmodule

//--- hdl/conv3x3_layer.sv
`timescale 1ns/10ps
`include "cnn_cfg.svh"

module conv3x3_layer (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    w_valid,
	input  cnn_data_pkg::pix_vec_t  w_data,
	input  logic                    b_valid,
	input  cnn_data_pkg::bias_t     b_data,
	input  logic                    pix_valid,
	input  cnn_data_pkg::pix_vec_t  pix_data,
	output logic                    coeff_ready,
	output cnn_stream_pkg::result_t out
);

	import cnn_data_pkg::*;
	import cnn_stream_pkg::*;

	kernel_t   kernels [`CNN_OUT_CH];
	bias_t     biases [`CNN_OUT_CH];
	win_beat_t win;
	tap_beat_t taps;

	// static once loaded
	coeff_loader u_coeff_loader (
		.clk         (clk),
		.rst         (rst),
		.w_valid     (w_valid),
		.w_data      (w_data),
		.b_valid     (b_valid),
		.b_data      (b_data),
		.kernels     (kernels),
		.biases      (biases),
		.coeff_ready (coeff_ready)
	);

	window_gen u_window_gen (
		.clk         (clk),
		.rst         (rst),
		.pix_valid   (pix_valid),
		.pix_data    (pix_data),
		.coeff_ready (coeff_ready),
		.win         (win)
	);

	conv_mac u_conv_mac (
		.clk     (clk),
		.rst     (rst),
		.win     (win),
		.kernels (kernels),
		.taps    (taps)
	);

	adder_tree u_adder_tree (
		.clk    (clk),
		.rst    (rst),
		.taps   (taps),
		.biases (biases),
		.res    (out)
	);

endmodule

//--- hdl/conv_mac.sv
`timescale 1ns/10ps
`include "cnn_cfg.svh"

module conv_mac (
	input  logic                      clk,
	input  logic                      rst,
	input  cnn_stream_pkg::win_beat_t win,
	input  cnn_data_pkg::kernel_t     kernels [`CNN_OUT_CH],
	output cnn_stream_pkg::tap_beat_t taps
);

	import cnn_data_pkg::*;
	import cnn_stream_pkg::*;

	logic      taps_valid;
	pos_t      taps_pos;
	tap_sums_t sums_d;
	tap_sums_t sums_q;

	// signed dot product over input channels
	function automatic acc_t dot(input pix_vec_t p, input pix_vec_t w);
		acc_t s;
		s = '0;
		for (int i = 0; i < `CNN_IN_CH; i++)
			s = s + acc_t'(p[i]) * acc_t'(w[i]);
		return s;
	endfunction

	always_comb
	begin
		for (int oc = 0; oc < `CNN_OUT_CH; oc++)
			for (int t = 0; t < `CNN_TAPS; t++)
				sums_d[oc][t] = dot(win.window[t], kernels[oc][t]);
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			taps_valid <= 1'b0;
		else
			taps_valid <= win.valid;
	end

	always_ff @(posedge clk)
	begin
		taps_pos <= win.pos;
		sums_q   <= sums_d;
	end

	assign taps = '{valid: taps_valid, pos: taps_pos, sums: sums_q};

endmodule

//--- hdl/window_gen.sv
`timescale 1ns/10ps
`include "cnn_cfg.svh"

module window_gen (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     pix_valid,
	input  cnn_data_pkg::pix_vec_t   pix_data,
	input  logic                     coeff_ready,
	output cnn_stream_pkg::win_beat_t win
);

	import cnn_data_pkg::*;
	import cnn_stream_pkg::*;

	localparam int K = `CNN_KSIZE;
	localparam int W = `CNN_WIDTH;

	logic     accept;
	coord_t   row;
	coord_t   col;
	logic     win_valid;
	pos_t     win_pos;
	window_t  win_taps;

	// one and two rows back
	pix_vec_t line1 [W];
	pix_vec_t line2 [W];

	assign accept = pix_valid & coeff_ready;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			row       <= '0;
			col       <= '0;
			win_valid <= 1'b0;
		end
		else
		begin
			win_valid <= accept && (row >= coord_t'(K - 1)) && (col >= coord_t'(K - 1));
			if (accept)
			begin
				if (col == coord_t'(W - 1))
				begin
					col <= '0;
					row <= (row == coord_t'(`CNN_HEIGHT - 1)) ? '0 : row + 1'b1;
				end
				else
					col <= col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			win_pos.row  <= row - coord_t'(K - 1);
			win_pos.col  <= col - coord_t'(K - 1);
			win_pos.last <= (row == coord_t'(`CNN_HEIGHT - 1)) && (col == coord_t'(W - 1));

			line1[0] <= pix_data;
			line2[0] <= line1[W-1];
			for (int i = 1; i < W; i++)
			begin
				line1[i] <= line1[i-1];
				line2[i] <= line2[i-1];
			end

			// window columns move left, newest column enters on the right
			for (int r = 0; r < K; r++)
				for (int c = 0; c < K - 1; c++)
					win_taps[r*K+c] <= win_taps[r*K+c+1];
			win_taps[K-1]   <= line2[W-1];
			win_taps[2*K-1] <= line1[W-1];
			win_taps[K*K-1] <= pix_data;
		end
	end

	assign win = '{valid: win_valid, pos: win_pos, window: win_taps};

	a_pos_range: assert property (@(posedge clk) disable iff (rst)
		win.valid |-> (win.pos.row < `CNN_HEIGHT - 2) && (win.pos.col < `CNN_WIDTH - 2))
		else $error("window position out of range");

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_conv3x3_layer

sim_out=$(./obj_dir/Vtb_conv3x3_layer)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'Done: no errors'
then
	exit 0
fi
exit 1

//--- test/conv_trace.txt
// weights: one line per output channel, taps 0..8, word = {ch3, ch2, ch1, ch0}
// then biases ch0..ch3, pixel rows 0..4, expected: row col last res0 res1 res2 res3
00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008 00000009
00000200 00000000 00000000 00000000 00010000 00000000 00000000 00000000 0000fd00
ff000000 ff000000 ff000005 ff000000 ff000000 ff000000 fffc0000 ff000000 ff000000
00000000 00000000 00000000 00000080 00000000 04030201 00000000 00009c00 00000000
// biases
0064 ffce 03e8 fc18
// pixels
00000000 0001fc04 0002f808 0003f40c 0004f010 0005ec14
02ffe818 0200e41c 0201e020 0202dc24 0203d828 0204d42c
04fed030 04ffcc34 0400c838 0401c43c 0402c040 0403bc44
06fdb848 06feb44c 06ffb050 0600ac54 0601a858 0602a45c
08fca060 08fd9c64 08fe9868 08ff946c 08009070 08018c74
// expected results
0 0 0 000718 000076 000406 000453
0 1 0 0007cc 00007b 000416 0003e2
0 2 0 000880 000080 000426 000371
0 3 0 000934 000085 000436 000300
1 0 0 000b50 00008d 000470 0001a0
1 1 0 000c04 000092 000480 00012f
1 2 0 000cb8 000097 000490 0000be
1 3 0 000d6c 00009c 0004a0 00004d
2 0 0 000f88 0000a4 0004da fffeed
2 1 0 00103c 0000a9 0004ea fffe7c
2 2 0 0010f0 0000ae 0004fa fffe0b
2 3 1 0011a4 0000b3 00050a fffd9a

//--- test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic rst
);

	localparam int PERIOD_NS    = 100;
	localparam int RESET_CYCLES = 3;

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- test/tb_conv3x3_layer.sv
`timescale 1ns/10ps
`include "cnn_cfg.svh"

module tb_conv3x3_layer;

	import cnn_data_pkg::*;
	import cnn_stream_pkg::*;

	localparam int W_WORDS   = `CNN_OUT_CH * `CNN_TAPS;
	localparam int B_BASE    = W_WORDS;
	localparam int P_BASE    = B_BASE + `CNN_OUT_CH;
	localparam int PIX_WORDS = `CNN_WIDTH * `CNN_HEIGHT;
	localparam int E_BASE    = P_BASE + PIX_WORDS;
	localparam int N_RESULTS = (`CNN_HEIGHT - 2) * (`CNN_WIDTH - 2);
	localparam int EXP_COLS  = 3 + `CNN_OUT_CH;
	localparam int TRACE_LEN = E_BASE + N_RESULTS * EXP_COLS;
	localparam int N_FRAMES  = 2;
	localparam int TIMEOUT   = 200;

	logic        clk;
	logic        rst;
	logic        w_valid;
	pix_vec_t    w_data;
	logic        b_valid;
	bias_t       b_data;
	logic        pix_valid;
	pix_vec_t    pix_data;
	logic        coeff_ready;
	result_t     out;
	logic [31:0] trace [TRACE_LEN];
	integer      seed;
	int          err_cnt = 0;
	int          check_cnt = 0;
	int          edge_cnt = 0;
	int          out_cnt = 0;
	int          in_row = 0;
	int          in_col = 0;
	int          exp_edge [$];

	tb_clock u_clock (
		.clk (clk),
		.rst (rst)
	);

	conv3x3_layer u_conv3x3_layer (
		.clk         (clk),
		.rst         (rst),
		.w_valid     (w_valid),
		.w_data      (w_data),
		.b_valid     (b_valid),
		.b_data      (b_data),
		.pix_valid   (pix_valid),
		.pix_data    (pix_data),
		.coeff_ready (coeff_ready),
		.out         (out)
	);

	task automatic compare_value(input string name, input int exp, input int act);
		check_cnt++;
		assert (exp == act)
		else
		begin
			err_cnt++;
			$display("MISMATCH %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic require_cond(input bit cond, input string what);
		check_cnt++;
		assert (cond)
		else
		begin
			err_cnt++;
			$display("ERROR %s", what);
		end
	endtask

	always @(posedge clk)
		edge_cnt <= edge_cnt + 1;

	// a pixel seen here is sampled on the next rising edge,
	// its result shows up two edges after that
	always @(negedge clk)
	begin
		if (!rst && pix_valid && coeff_ready)
		begin
			if (in_row >= 2 && in_col >= 2)
				exp_edge.push_back(edge_cnt + 3);
			if (in_col == `CNN_WIDTH - 1)
			begin
				in_col = 0;
				in_row = (in_row == `CNN_HEIGHT - 1) ? 0 : in_row + 1;
			end
			else
				in_col = in_col + 1;
		end
	end

	task automatic score_output();
		int    idx;
		int    base;
		int    oc;
		int    due;
		string name;
		acc_t  exp_acc;
		acc_t  act_acc;
		idx  = out_cnt % N_RESULTS;
		base = E_BASE + idx * EXP_COLS;
		name = $sformatf("frame %0d output %0d", out_cnt / N_RESULTS, idx);
		out_cnt++;
		require_cond(out_cnt <= N_FRAMES * N_RESULTS, "output after the last expected result");
		require_cond(exp_edge.size() > 0, "output without a completing pixel");
		if (exp_edge.size() > 0)
		begin
			due = exp_edge.pop_front();
			compare_value({name, " edge"}, due, edge_cnt);
		end
		compare_value({name, " row"}, trace[base], out.pos.row);
		compare_value({name, " col"}, trace[base + 1], out.pos.col);
		compare_value({name, " last"}, trace[base + 2], out.pos.last);
		for (oc = 0; oc < `CNN_OUT_CH; oc++)
		begin
			exp_acc = trace[base + 3 + oc][`CNN_ACC_W-1:0];
			act_acc = out.data[oc];
			compare_value($sformatf("%s ch%0d", name, oc), exp_acc, act_acc);
		end
	endtask

	always @(negedge clk)
	begin
		if (!rst && out.valid)
			score_output();
	end

	task automatic wait_reset_release(output bit ok);
		int n;
		n = 0;
		while (rst && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		ok = !rst;
		require_cond(ok, "timeout waiting for reset release");
	endtask

	task automatic wait_coeff_ready(output bit ok);
		int n;
		n = 0;
		while (!coeff_ready && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		ok = coeff_ready;
		require_cond(ok, "timeout waiting for coeff_ready");
	endtask

	task automatic wait_outputs(output bit ok);
		int n;
		n = 0;
		while (out_cnt < N_FRAMES * N_RESULTS && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		ok = (out_cnt >= N_FRAMES * N_RESULTS);
		require_cond(ok, "timeout waiting for all results");
	endtask

	task automatic drive_pixel(input pix_vec_t data);
		@(posedge clk);
		pix_valid <= 1'b1;
		pix_data  <= data;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		pix_valid <= 1'b0;
	endtask

	task automatic load_coefficients();
		int k;
		for (k = 0; k < W_WORDS; k++)
		begin
			@(posedge clk);
			w_valid <= 1'b1;
			w_data  <= trace[k];
			@(negedge clk);
			compare_value($sformatf("coeff_ready at weight %0d", k), 0, coeff_ready);
		end
		@(posedge clk);
		w_valid <= 1'b0;
		for (k = 0; k < `CNN_OUT_CH; k++)
		begin
			b_valid <= 1'b1;
			b_data  <= trace[B_BASE + k][`CNN_BIAS_W-1:0];
			@(negedge clk);
			compare_value($sformatf("coeff_ready at bias %0d", k), 0, coeff_ready);
			@(posedge clk);
		end
		b_valid <= 1'b0;
	endtask

	task automatic send_frame(input bit gaps);
		int i;
		int g;
		int gap;
		for (i = 0; i < PIX_WORDS; i++)
		begin
			gap = gaps ? {$random(seed)} % 3 : 0;
			for (g = 0; g < gap; g++)
				drive_idle();
			drive_pixel(trace[P_BASE + i]);
		end
	endtask

	task automatic run_sequence();
		bit ok;
		int n;
		wait_reset_release(ok);
		if (!ok)
			return;
		compare_value("coeff_ready after reset", 0, coeff_ready);
		compare_value("out.valid after reset", 0, out.valid);
		require_cond(trace[TRACE_LEN - EXP_COLS + 2] == 1, "trace file missing or short");

		// ignored, coefficients are not loaded yet
		for (n = 0; n < 3; n++)
			drive_pixel($random(seed));
		drive_idle();
		repeat (8) @(negedge clk);
		compare_value("outputs from early pixels", 0, out_cnt);
		compare_value("coeff_ready after early pixels", 0, coeff_ready);

		load_coefficients();
		wait_coeff_ready(ok);
		if (!ok)
			return;

		send_frame(1'b1);
		send_frame(1'b0);
		drive_idle();
		wait_outputs(ok);
		if (!ok)
			return;
		repeat (6) @(negedge clk);
		compare_value("total outputs", N_FRAMES * N_RESULTS, out_cnt);
		compare_value("results still pending", 0, exp_edge.size());
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	initial
	begin
		seed      = 3;
		w_valid   = 1'b0;
		w_data    = '0;
		b_valid   = 1'b0;
		b_data    = '0;
		pix_valid = 1'b0;
		pix_data  = '0;
		$readmemh("test/conv_trace.txt", trace);
		run_sequence();
		finish_run();
	end

endmodule
